// ==== src/decode_defs.svh ====
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

`define DATA_W       32
`define REG_ADDR_W   5
`define ALU_OP_W     12
`define EXC_W        5
`define IMM_W        16

// primary opcodes
`define OPC_SPECIAL  6'h00
`define OPC_REGIMM   6'h01
`define OPC_J        6'h02
`define OPC_JAL      6'h03
`define OPC_BEQ      6'h04
`define OPC_BNE      6'h05
`define OPC_BLEZ     6'h06
`define OPC_BGTZ     6'h07
`define OPC_ADDI     6'h08
`define OPC_ADDIU    6'h09
`define OPC_SLTI     6'h0a
`define OPC_SLTIU    6'h0b
`define OPC_ANDI     6'h0c
`define OPC_ORI      6'h0d
`define OPC_XORI     6'h0e
`define OPC_LUI      6'h0f
`define OPC_LB       6'h20
`define OPC_LH       6'h21
`define OPC_LW       6'h23
`define OPC_LBU      6'h24
`define OPC_LHU      6'h25
`define OPC_SB       6'h28
`define OPC_SH       6'h29
`define OPC_SW       6'h2b

// SPECIAL function field
`define FN_SLL       6'h00
`define FN_SRL       6'h02
`define FN_SRA       6'h03
`define FN_SLLV      6'h04
`define FN_SRLV      6'h06
`define FN_SRAV      6'h07
`define FN_JR        6'h08
`define FN_JALR      6'h09
`define FN_ADD       6'h20
`define FN_ADDU      6'h21
`define FN_SUB       6'h22
`define FN_SUBU      6'h23
`define FN_AND       6'h24
`define FN_OR        6'h25
`define FN_XOR       6'h26
`define FN_NOR       6'h27
`define FN_SLT       6'h2a
`define FN_SLTU      6'h2b

// REGIMM rt field
`define RT_BLTZ      5'h00
`define RT_BGEZ      5'h01
`define RT_BLTZAL    5'h10
`define RT_BGEZAL    5'h11

`define MEM_SIZE_BYTE 2'd0
`define MEM_SIZE_HALF 2'd1
`define MEM_SIZE_WORD 2'd2

`define EX_RI        5'h0a

`endif

// ==== src/decode_pkg.sv ====
`include "decode_defs.svh"

package decode_pkg;

    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ALU_OP_W-1:0]   alu_op_t;
    typedef logic [`EXC_W-1:0]      exccode_t;
    typedef logic [1:0]             mem_size_t;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_bus_t;

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    // a later stage as seen from decode
    typedef struct packed {
        logic      valid;
        logic      we;
        logic      is_load;
        reg_addr_t dest;
        word_t     value;
    } fwd_src_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      ov_op;
        logic      src1_is_sa;
        logic      src1_is_pc;
        logic      src2_is_signed_imm;
        logic      src2_is_zero_imm;
        logic      src2_is_8;
        logic      load_op;
        logic      load_unsigned;
        logic      mem_we;
        mem_size_t mem_size;
        logic      gr_we;
        reg_addr_t dest;
        // bgez and bltz also cover the linking forms
        logic      is_beq;
        logic      is_bne;
        logic      is_bgez;
        logic      is_bgtz;
        logic      is_blez;
        logic      is_bltz;
        logic      is_jump_imm;
        logic      is_jump_reg;
        logic      illegal;
    } decode_ctrl_t;

    typedef struct packed {
        logic  br_taken;
        word_t br_target;
    } branch_bus_t;

    typedef struct packed {
        logic               ex;
        exccode_t           exccode;
        decode_ctrl_t       ctrl;
        logic [`IMM_W-1:0]  imm;
        word_t              rs_value;
        word_t              rt_value;
        word_t              pc;
    } issue_bus_t;

endpackage

// ==== src/inst_decoder.sv ====
`timescale 1ns/1ns
`include "decode_defs.svh"

module inst_decoder (
    input  decode_pkg::word_t        inst,
    output decode_pkg::decode_ctrl_t ctrl
);
    import decode_pkg::*;

    logic [5:0] op, func;
    logic [4:0] sa;
    reg_addr_t  rs, rt, rd;
    logic       special, regimm, sa_zero;
    logic       i_add, i_addu, i_sub, i_subu, i_slt, i_sltu;
    logic       i_and, i_or, i_xor, i_nor;
    logic       i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav;
    logic       i_addi, i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic       i_lb, i_lbu, i_lh, i_lhu, i_lw, i_sb, i_sh, i_sw;
    logic       i_beq, i_bne, i_bgez, i_bgtz, i_blez, i_bltz, i_bgezal, i_bltzal;
    logic       i_j, i_jal, i_jr, i_jalr;
    logic       is_load, is_store, is_branch, is_alu_r, is_alu_i, dst_is_r31, dst_is_rt;

    assign op      = inst[31:26];
    assign rs      = inst[25:21];
    assign rt      = inst[20:16];
    assign rd      = inst[15:11];
    assign sa      = inst[10:6];
    assign func    = inst[5:0];
    assign special = (op == `OPC_SPECIAL);
    assign regimm  = (op == `OPC_REGIMM);
    assign sa_zero = (sa == 5'd0);

    // register forms need a zero shift field
    assign i_add   = special && func == `FN_ADD  && sa_zero;
    assign i_addu  = special && func == `FN_ADDU && sa_zero;
    assign i_sub   = special && func == `FN_SUB  && sa_zero;
    assign i_subu  = special && func == `FN_SUBU && sa_zero;
    assign i_slt   = special && func == `FN_SLT  && sa_zero;
    assign i_sltu  = special && func == `FN_SLTU && sa_zero;
    assign i_and   = special && func == `FN_AND  && sa_zero;
    assign i_or    = special && func == `FN_OR   && sa_zero;
    assign i_xor   = special && func == `FN_XOR  && sa_zero;
    assign i_nor   = special && func == `FN_NOR  && sa_zero;
    assign i_sllv  = special && func == `FN_SLLV && sa_zero;
    assign i_srlv  = special && func == `FN_SRLV && sa_zero;
    assign i_srav  = special && func == `FN_SRAV && sa_zero;
    assign i_sll   = special && func == `FN_SLL  && rs == '0;
    assign i_srl   = special && func == `FN_SRL  && rs == '0;
    assign i_sra   = special && func == `FN_SRA  && rs == '0;
    assign i_jr    = special && func == `FN_JR   && rt == '0 && rd == '0 && sa_zero;
    assign i_jalr  = special && func == `FN_JALR && rt == '0 && sa_zero;

    assign i_addi  = (op == `OPC_ADDI);
    assign i_addiu = (op == `OPC_ADDIU);
    assign i_slti  = (op == `OPC_SLTI);
    assign i_sltiu = (op == `OPC_SLTIU);
    assign i_andi  = (op == `OPC_ANDI);
    assign i_ori   = (op == `OPC_ORI);
    assign i_xori  = (op == `OPC_XORI);
    assign i_lui   = (op == `OPC_LUI) && rs == '0;
    assign i_lb    = (op == `OPC_LB);
    assign i_lbu   = (op == `OPC_LBU);
    assign i_lh    = (op == `OPC_LH);
    assign i_lhu   = (op == `OPC_LHU);
    assign i_lw    = (op == `OPC_LW);
    assign i_sb    = (op == `OPC_SB);
    assign i_sh    = (op == `OPC_SH);
    assign i_sw    = (op == `OPC_SW);

    assign i_beq    = (op == `OPC_BEQ);
    assign i_bne    = (op == `OPC_BNE);
    assign i_blez   = (op == `OPC_BLEZ) && rt == '0;
    assign i_bgtz   = (op == `OPC_BGTZ) && rt == '0;
    assign i_bltz   = regimm && rt == `RT_BLTZ;
    assign i_bgez   = regimm && rt == `RT_BGEZ;
    assign i_bltzal = regimm && rt == `RT_BLTZAL;
    assign i_bgezal = regimm && rt == `RT_BGEZAL;
    assign i_j      = (op == `OPC_J);
    assign i_jal    = (op == `OPC_JAL);

    assign is_load   = i_lb | i_lbu | i_lh | i_lhu | i_lw;
    assign is_store  = i_sb | i_sh | i_sw;
    assign is_branch = i_beq | i_bne | i_bgez | i_bgtz | i_blez | i_bltz | i_j | i_jr;
    assign is_alu_r  = i_add | i_addu | i_sub | i_subu | i_slt | i_sltu | i_and | i_or
                     | i_xor | i_nor | i_sll | i_srl | i_sra | i_sllv | i_srlv | i_srav;
    assign is_alu_i  = i_addi | i_addiu | i_slti | i_sltiu | i_andi | i_ori | i_xori | i_lui;
    assign dst_is_r31 = i_bgezal | i_bltzal | i_jal;
    assign dst_is_rt  = is_alu_i | is_load;

    // one-hot, same bit order as the execute ALU
    assign ctrl.alu_op[0]  = i_add | i_addu | i_addi | i_addiu | is_load | is_store
                           | i_bgezal | i_bltzal | i_jal | i_jalr;
    assign ctrl.alu_op[1]  = i_sub | i_subu;
    assign ctrl.alu_op[2]  = i_slt | i_slti;
    assign ctrl.alu_op[3]  = i_sltu | i_sltiu;
    assign ctrl.alu_op[4]  = i_and | i_andi;
    assign ctrl.alu_op[5]  = i_nor;
    assign ctrl.alu_op[6]  = i_or | i_ori;
    assign ctrl.alu_op[7]  = i_xor | i_xori;
    assign ctrl.alu_op[8]  = i_sll | i_sllv;
    assign ctrl.alu_op[9]  = i_srl | i_srlv;
    assign ctrl.alu_op[10] = i_sra | i_srav;
    assign ctrl.alu_op[11] = i_lui;

    assign ctrl.ov_op              = i_add | i_addi | i_sub;
    assign ctrl.src1_is_sa         = i_sll | i_srl | i_sra;
    assign ctrl.src1_is_pc         = dst_is_r31 | i_jalr;
    assign ctrl.src2_is_signed_imm = i_addi | i_addiu | i_slti | i_sltiu | i_lui | is_load | is_store;
    assign ctrl.src2_is_zero_imm   = i_andi | i_ori | i_xori;
    assign ctrl.src2_is_8          = dst_is_r31 | i_jalr;

    assign ctrl.load_op       = is_load;
    assign ctrl.load_unsigned = i_lbu | i_lhu;
    assign ctrl.mem_we        = is_store;
    assign ctrl.mem_size      = (i_lb | i_lbu | i_sb) ? `MEM_SIZE_BYTE :
                                (i_lh | i_lhu | i_sh) ? `MEM_SIZE_HALF :
                                                        `MEM_SIZE_WORD;

    assign ctrl.gr_we = is_alu_r | is_alu_i | is_load | dst_is_r31 | i_jalr;
    assign ctrl.dest  = dst_is_r31 ? 5'd31 :
                        dst_is_rt  ? rt    :
                                     rd;

    assign ctrl.is_beq      = i_beq;
    assign ctrl.is_bne      = i_bne;
    assign ctrl.is_bgez     = i_bgez | i_bgezal;
    assign ctrl.is_bgtz     = i_bgtz;
    assign ctrl.is_blez     = i_blez;
    assign ctrl.is_bltz     = i_bltz | i_bltzal;
    assign ctrl.is_jump_imm = i_j | i_jal;
    assign ctrl.is_jump_reg = i_jr | i_jalr;

    assign ctrl.illegal = ~(is_alu_r | is_alu_i | is_load | is_store | is_branch
                          | dst_is_r31 | i_jalr);

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ns
`include "decode_defs.svh"

module regfile (
    input  logic                   clk,
    input  decode_pkg::reg_addr_t  raddr1,
    input  decode_pkg::reg_addr_t  raddr2,
    output decode_pkg::word_t      rdata1,
    output decode_pkg::word_t      rdata2,
    input  decode_pkg::rf_write_t  wr
);
    import decode_pkg::*;

    word_t regs [0:(1 << `REG_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // $0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== src/operand_bypass.sv ====
`timescale 1ns/1ns

module operand_bypass (
    input  decode_pkg::reg_addr_t rs,
    input  decode_pkg::reg_addr_t rt,
    input  decode_pkg::word_t     rf_rs,
    input  decode_pkg::word_t     rf_rt,
    input  decode_pkg::fwd_src_t  es_fwd,
    input  decode_pkg::fwd_src_t  ms_fwd,
    input  decode_pkg::fwd_src_t  ws_fwd,
    output decode_pkg::word_t     rs_value,
    output decode_pkg::word_t     rt_value,
    output logic                  stall
);
    import decode_pkg::*;

    function automatic logic hit(input fwd_src_t src, input reg_addr_t addr);
        return src.valid && src.we && addr != '0 && src.dest == addr;
    endfunction

    // youngest result wins
    function automatic word_t pick(input reg_addr_t addr, input word_t rf_value,
                                   input fwd_src_t es, input fwd_src_t ms,
                                   input fwd_src_t ws);
        if (hit(es, addr)) return es.value;
        if (hit(ms, addr)) return ms.value;
        if (hit(ws, addr)) return ws.value;
        return rf_value;
    endfunction

    assign rs_value = pick(rs, rf_rs, es_fwd, ms_fwd, ws_fwd);
    assign rt_value = pick(rt, rf_rt, es_fwd, ms_fwd, ws_fwd);

    // load data not ready until memory stage
    assign stall = es_fwd.valid && es_fwd.is_load && es_fwd.dest != '0
                && (es_fwd.dest == rs || es_fwd.dest == rt);

endmodule

// ==== src/branch_unit.sv ====
`timescale 1ns/1ns

module branch_unit (
    input  logic                     valid,
    input  decode_pkg::decode_ctrl_t ctrl,
    input  decode_pkg::word_t        pc,
    input  logic [25:0]              imm_field,
    input  decode_pkg::word_t        rs_value,
    input  decode_pkg::word_t        rt_value,
    output decode_pkg::branch_bus_t  branch
);
    import decode_pkg::*;

    word_t pc_plus4, br_offset;
    logic  rs_eq_rt, rs_eq_zero, rs_lt_zero, is_cond, cond_met;

    assign pc_plus4  = pc + 32'd4;
    assign br_offset = {{14{imm_field[15]}}, imm_field[15:0], 2'b00};

    assign rs_eq_rt   = (rs_value == rt_value);
    assign rs_eq_zero = (rs_value == '0);
    assign rs_lt_zero = rs_value[31];

    assign is_cond = ctrl.is_beq | ctrl.is_bne | ctrl.is_bgez | ctrl.is_bgtz
                   | ctrl.is_blez | ctrl.is_bltz;

    assign cond_met = (ctrl.is_beq  &&  rs_eq_rt)
                   || (ctrl.is_bne  && !rs_eq_rt)
                   || (ctrl.is_bgez && !rs_lt_zero)
                   || (ctrl.is_bgtz && !rs_lt_zero && !rs_eq_zero)
                   || (ctrl.is_blez && (rs_lt_zero || rs_eq_zero))
                   || (ctrl.is_bltz &&  rs_lt_zero);

    assign branch.br_taken = valid && (cond_met || ctrl.is_jump_imm || ctrl.is_jump_reg);

    // j/jal stay inside the 256MB region of the delay slot
    assign branch.br_target = is_cond          ? pc_plus4 + br_offset :
                              ctrl.is_jump_reg ? rs_value :
                                                 {pc_plus4[31:28], imm_field, 2'b00};

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/1ns
`include "decode_defs.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    fetch_valid,
    input  decode_pkg::fetch_bus_t  fetch_bus,
    output logic                    allowin,
    input  logic                    es_allowin,
    input  decode_pkg::fwd_src_t    es_fwd,
    input  decode_pkg::fwd_src_t    ms_fwd,
    input  decode_pkg::fwd_src_t    ws_fwd,
    output logic                    out_valid,
    output decode_pkg::issue_bus_t  issue,
    output decode_pkg::branch_bus_t branch
);
    import decode_pkg::*;

    logic         ds_valid, ready, stall;
    fetch_bus_t   ds_bus;
    decode_ctrl_t ctrl;
    rf_write_t    rf_wr;
    reg_addr_t    rs, rt;
    word_t        rf_rs, rf_rt, rs_value, rt_value;

    assign ready     = !stall;
    assign allowin   = !ds_valid || (ready && es_allowin);
    assign out_valid = ds_valid && ready;

    // flush beats a new instruction
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ds_valid <= 1'b0;
        end else if (allowin) begin
            ds_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && allowin) begin
            ds_bus <= fetch_bus;
        end
    end

    assign rs = ds_bus.inst[25:21];
    assign rt = ds_bus.inst[20:16];

    assign rf_wr.we   = ws_fwd.valid && ws_fwd.we;
    assign rf_wr.addr = ws_fwd.dest;
    assign rf_wr.data = ws_fwd.value;

    inst_decoder u_inst_decoder (
        .inst (ds_bus.inst),
        .ctrl (ctrl)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rs),
        .rdata2 (rf_rt),
        .wr     (rf_wr)
    );

    operand_bypass u_operand_bypass (
        .rs       (rs),
        .rt       (rt),
        .rf_rs    (rf_rs),
        .rf_rt    (rf_rt),
        .es_fwd   (es_fwd),
        .ms_fwd   (ms_fwd),
        .ws_fwd   (ws_fwd),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .stall    (stall)
    );

    branch_unit u_branch_unit (
        .valid     (ds_valid),
        .ctrl      (ctrl),
        .pc        (ds_bus.pc),
        .imm_field (ds_bus.inst[25:0]),
        .rs_value  (rs_value),
        .rt_value  (rt_value),
        .branch    (branch)
    );

    assign issue.ex       = ds_valid && ctrl.illegal;
    assign issue.exccode  = ctrl.illegal ? `EX_RI : '0;
    assign issue.ctrl     = ctrl;
    assign issue.imm      = ds_bus.inst[15:0];
    assign issue.rs_value = rs_value;
    assign issue.rt_value = rt_value;
    assign issue.pc       = ds_bus.pc;

endmodule

// ==== verification/tb_decode_stage.sv ====
`timescale 1ns/1ns
`include "decode_defs.svh"

module tb_decode_stage;
    import decode_pkg::*;

    logic        clk, reset, flush, fetch_valid, es_allowin, allowin, out_valid;
    fetch_bus_t  fetch_bus;
    fwd_src_t    es_fwd, ms_fwd, ws_fwd;
    issue_bus_t  issue, held;
    branch_bus_t branch;
    logic [31:0] lfsr;
    word_t       rf_model [0:31] = '{default: '0};

    decode_stage u_decode_stage (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // register file as the write-back port should leave it
    always @(posedge clk) begin
        if (ws_fwd.valid && ws_fwd.we && ws_fwd.dest != '0) begin
            rf_model[ws_fwd.dest] <= ws_fwd.value;
        end
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic flag_error(input string msg);
        abort_run($sformatf("Error at %0t ns: %s", $time, msg));
    endtask

    task automatic check(input logic ok, input string msg);
        assert (ok) else flag_error(msg);
    endtask

    assert property (@(posedge clk) disable iff (reset) out_valid |-> allowin == es_allowin)
        else flag_error("allowin does not follow es_allowin while issuing");
    assert property (@(posedge clk) disable iff (reset) issue.ex |-> issue.exccode == `EX_RI)
        else flag_error("exception raised with a wrong exccode");
    assert property (@(posedge clk) reset |=> !out_valid && !branch.br_taken)
        else flag_error("stage not empty after a reset edge");

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t enc_r(input reg_addr_t rs, rt, rd, input logic [5:0] fn);
        return {`OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs, rt,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic fwd_src_t make_fwd(input logic load, input reg_addr_t dest,
                                          input word_t value);
        fwd_src_t f;
        f.valid   = 1'b1;
        f.we      = 1'b1;
        f.is_load = load;
        f.dest    = dest;
        f.value   = value;
        return f;
    endfunction

    function automatic word_t cond_target(input word_t pc, input logic [15:0] off);
        return pc + 32'd4 + {{14{off[15]}}, off, 2'b00};
    endfunction

    function automatic word_t jump_target(input word_t pc, input logic [25:0] idx);
        word_t next_pc;
        next_pc = pc + 32'd4;
        return {next_pc[31:28], idx, 2'b00};
    endfunction

    // returns at the negedge after the accepting edge
    task automatic load_inst(input word_t inst, input word_t pc);
        int n;
        n = 0;
        @(negedge clk);
        while (!allowin) begin
            n++;
            if (n > 20) abort_run("timed out waiting for allowin before a fetch");
            @(negedge clk);
        end
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_bus   <= {pc, inst};
        @(posedge clk);
        fetch_valid <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_out_valid();
        int n;
        n = 0;
        while (!out_valid) begin
            n++;
            if (n > 20) abort_run("timed out waiting for out_valid after a stall");
            @(negedge clk);
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input word_t data);
        @(posedge clk);
        ws_fwd <= make_fwd(1'b0, addr, data);
        @(posedge clk);
        ws_fwd <= '0;
    endtask

    task automatic check_branch(input word_t inst, input word_t pc, input logic taken,
                                input word_t target);
        load_inst(inst, pc);
        check(branch.br_taken == taken,
              $sformatf("br_taken %0b, expected %0b for inst %h", branch.br_taken, taken, inst));
        check(branch.br_target == target,
              $sformatf("br_target %h, expected %h for inst %h", branch.br_target, target, inst));
    endtask

    initial begin
        word_t       pc, v;
        reg_addr_t   ra;
        logic [15:0] off;
        logic        tk;
        lfsr        = 32'he4ca;
        reset       = 1'b1;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_bus   = '0;
        es_allowin  = 1'b1;
        es_fwd      = '0;
        ms_fwd      = '0;
        ws_fwd      = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check(!out_valid && !branch.br_taken && allowin, "idle outputs wrong after reset");

        // every register gets a value including register 0
        for (int r = 0; r < 32; r++) begin
            write_reg(reg_addr_t'(r), rand_bits(32));
        end

        load_inst(enc_r(5'd1, 5'd2, 5'd3, `FN_ADDU), 32'h0040_0000);
        check(out_valid, "out_valid low after an accepted addu");
        @(posedge clk);
        es_allowin <= 1'b0;
        load_inst(enc_r(5'd4, 5'd5, 5'd6, `FN_SUBU), 32'h0040_0004);
        held = issue;
        repeat (3) begin
            @(negedge clk);
            check(out_valid && !allowin && issue === held, "stage did not hold under back-pressure");
        end
        @(posedge clk);
        es_allowin <= 1'b1;

        for (int i = 0; i < 8; i++) begin
            ra = reg_addr_t'(rand_bits(5));
            v  = rand_bits(5);
            load_inst(enc_r(ra, reg_addr_t'(v), 5'd1, `FN_OR), 32'h0040_0100);
            check(issue.rs_value == rf_model[ra] && issue.rt_value == rf_model[v[4:0]],
                  $sformatf("read-back of r%0d/r%0d wrong", ra, v[4:0]));
        end

        // zero register is neither stored nor forwarded
        @(posedge clk);
        ws_fwd <= make_fwd(1'b0, 5'd0, 32'hdead_beef);
        es_fwd <= make_fwd(1'b0, 5'd0, 32'h1234_5678);
        load_inst(enc_r(5'd0, 5'd0, 5'd7, `FN_ADDU), 32'h0040_0104);
        check(issue.rs_value == '0 && issue.rt_value == '0, "register 0 did not read as zero");

        @(posedge clk);
        es_allowin <= 1'b0;
        es_fwd     <= make_fwd(1'b0, 5'd9, rand_bits(32));
        ms_fwd     <= make_fwd(1'b0, 5'd9, rand_bits(32));
        ws_fwd     <= make_fwd(1'b0, 5'd9, rand_bits(32));
        load_inst(enc_r(5'd9, 5'd10, 5'd11, `FN_ADDU), 32'h0040_0200);
        check(issue.rs_value == es_fwd.value, "rs not taken from the execute stage");
        check(issue.rt_value == rf_model[10], "rt changed by an unrelated forward");
        @(posedge clk);
        es_fwd <= '0;
        @(negedge clk);
        check(issue.rs_value == ms_fwd.value, "rs not taken from the memory stage");
        @(posedge clk);
        ms_fwd <= '0;
        // new write-back value not yet in the register file
        ws_fwd <= make_fwd(1'b0, 5'd9, rand_bits(32));
        @(negedge clk);
        check(issue.rs_value == ws_fwd.value, "rs not taken from write-back");
        @(posedge clk);
        ws_fwd <= '0;
        @(negedge clk);
        check(issue.rs_value == rf_model[9], "rs not taken from the register file");
        @(posedge clk);
        es_allowin <= 1'b1;

        // load in execute feeding rt
        es_fwd <= make_fwd(1'b1, 5'd12, rand_bits(32));
        load_inst(enc_r(5'd3, 5'd12, 5'd13, `FN_ADDU), 32'h0040_0300);
        repeat (3) begin
            check(!out_valid && !allowin, "load-use stall did not hold the stage");
            @(negedge clk);
        end
        @(posedge clk);
        v = rand_bits(32);
        es_fwd <= '0;
        ms_fwd <= make_fwd(1'b1, 5'd12, v);
        @(negedge clk);
        wait_out_valid();
        check(issue.rs_value == rf_model[3] && issue.rt_value == v,
              "wrong operands after the load-use stall");
        @(posedge clk);
        ms_fwd <= '0;
        es_fwd <= make_fwd(1'b1, 5'd0, 32'h0bad_0bad);
        load_inst(enc_r(5'd2, 5'd0, 5'd14, `FN_ADDU), 32'h0040_0304);
        check(out_valid && issue.rt_value == '0, "load to register 0 stalled the stage");
        @(posedge clk);
        es_fwd <= '0;

        pc = 32'h0040_1000;
        tk = rf_model[16] == rf_model[17];
        check_branch(enc_i(`OPC_BEQ, 5'd15, 5'd15, 16'hfff0), pc, 1'b1, cond_target(pc, 16'hfff0));
        check_branch(enc_i(`OPC_BNE, 5'd15, 5'd15, 16'h0010), pc, 1'b0, cond_target(pc, 16'h0010));
        check_branch(enc_i(`OPC_BEQ, 5'd16, 5'd17, 16'h0020), pc, tk, cond_target(pc, 16'h0020));
        check_branch(enc_i(`OPC_BNE, 5'd16, 5'd17, 16'h8000), pc, !tk, cond_target(pc, 16'h8000));

        write_reg(5'd18, '0);
        for (int i = 0; i < 16; i++) begin
            ra  = (i >= 12) ? 5'd18 : reg_addr_t'(rand_bits(5));
            v   = rf_model[ra];
            off = 16'(rand_bits(16));
            pc  = rand_bits(32) & 32'hffff_fffc;
            case (i % 4)
                0: check_branch(enc_i(`OPC_REGIMM, ra, `RT_BGEZ, off), pc,
                                $signed(v) >= 0, cond_target(pc, off));
                1: check_branch(enc_i(`OPC_BGTZ, ra, 5'd0, off), pc,
                                $signed(v) > 0, cond_target(pc, off));
                2: check_branch(enc_i(`OPC_BLEZ, ra, 5'd0, off), pc,
                                $signed(v) <= 0, cond_target(pc, off));
                default: check_branch(enc_i(`OPC_REGIMM, ra, `RT_BLTZ, off), pc,
                                      $signed(v) < 0, cond_target(pc, off));
            endcase
        end

        // pc+4 crosses into the next 256MB region
        pc = 32'hafff_fffc;
        check_branch({`OPC_J, 26'h123_4567}, pc, 1'b1, jump_target(pc, 26'h123_4567));
        check_branch({`OPC_JAL, 26'h0ab_cdef}, pc, 1'b1, jump_target(pc, 26'h0ab_cdef));
        check(issue.ctrl.dest == 5'd31 && issue.ctrl.gr_we, "jal does not link into r31");
        check_branch(enc_r(5'd19, 5'd0, 5'd0, `FN_JR), pc, 1'b1, rf_model[19]);

        load_inst(enc_i(`OPC_ADDIU, 5'd1, 5'd20, 16'h8001), pc);
        check(issue.ctrl.dest == 5'd20 && issue.ctrl.src2_is_signed_imm && issue.ctrl.gr_we
              && !issue.ex && issue.imm == 16'h8001 && issue.pc == pc, "addiu decoded wrong");
        load_inst(enc_i(`OPC_SW, 5'd1, 5'd2, 16'h0004), pc);
        check(issue.ctrl.mem_we && !issue.ctrl.gr_we && issue.ctrl.mem_size == `MEM_SIZE_WORD,
              "sw decoded wrong");
        load_inst(enc_i(`OPC_LBU, 5'd1, 5'd21, 16'h0003), pc);
        check(issue.ctrl.load_op && issue.ctrl.load_unsigned
              && issue.ctrl.mem_size == `MEM_SIZE_BYTE, "lbu decoded wrong");
        load_inst({6'h3f, 26'h0}, pc);
        check(issue.ex && issue.exccode == `EX_RI && !branch.br_taken,
              "unused opcode did not raise a reserved-instruction exception");

        // reset while a taken jump is held
        @(posedge clk);
        es_allowin <= 1'b0;
        load_inst({`OPC_J, 26'h000_0040}, 32'h0040_3000);
        check(out_valid && branch.br_taken, "jump not held before reset");
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        reset <= 1'b0;

        @(posedge clk);
        es_allowin <= 1'b0;
        load_inst(enc_r(5'd1, 5'd2, 5'd3, `FN_ADDU), 32'h0040_2000);
        check(out_valid, "out_valid low before flush");
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush      <= 1'b0;
        es_allowin <= 1'b1;
        @(negedge clk);
        check(!out_valid && allowin, "flush did not empty the stage");

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== decode_stage.f ====
+incdir+src
src/decode_pkg.sv
src/inst_decoder.sv
src/regfile.sv
src/operand_bypass.sv
src/branch_unit.sv
src/decode_stage.sv
verification/tb_decode_stage.sv

// ==== Makefile ====
SIM       := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_decode_stage
FILELIST  := decode_stage.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	rm -f $(LOG)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
